// File: build.f
+incdir+.
mips_pkg.sv
pipe_intf.sv
alu.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
mips_core.sv
tb_mips_core.sv

// File: mips_ref.svh
`ifndef MIPS_REF_SVH
`define MIPS_REF_SVH

// instruction-level model of the program in prog without pipeline timing
// fills exp_wr and exp_st in program order and returns the executed count
function automatic int run_model();
	word_t     regs [0:31];
	word_t     mem [0:dmem_words-1];
	pc_t       pc;
	pc_t       next_pc;
	word_t     ins;
	word_t     a;
	word_t     b;
	word_t     imm_s;
	word_t     imm_z;
	word_t     res;
	reg_addr_t dst;
	logic      wr;
	int        steps;
	int        i;

	for (i = 0; i < 32; i++)
		regs[i] = '0;
	for (i = 0; i < dmem_words; i++)
		mem[i] = '0;
	pc    = '0;
	steps = 0;
	while (steps < max_steps)
	begin
		ins     = prog[pc];
		a       = regs[ins[25:21]];
		b       = regs[ins[20:16]];
		imm_s   = {{16{ins[15]}}, ins[15:0]};
		imm_z   = {16'b0, ins[15:0]}; // ori only
		next_pc = pc + 1;
		wr      = 1'b1;
		dst     = ins[20:16]; // rt unless R-type
		res     = '0;
		case (ins[31:26])
			op_rtype:
			begin
				dst = ins[15:11];
				case (ins[5:0])
					fn_add: res = a + b;
					fn_sub: res = a - b;
					fn_and: res = a & b;
					fn_or:  res = a | b;
					fn_xor: res = a ^ b;
					fn_nor: res = ~(a | b);
					fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					fn_sll: res = b << ins[10:6];
					fn_srl: res = b >> ins[10:6];
					fn_sra: res = $signed(b) >>> ins[10:6];
					default: wr = 1'b0;
				endcase
			end
			op_addi: res = a + imm_s;
			op_slti: res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
			op_andi: res = a & imm_s;
			op_ori:  res = a | imm_z;
			op_xori: res = a ^ imm_s;
			op_lw:   res = mem[(a + imm_s) % dmem_words];
			op_sw:
			begin
				wr = 1'b0;
				mem[(a + imm_s) % dmem_words] = b;
				exp_st.push_back({steps, prog_tag[pc], a + imm_s, b});
			end
			op_beq, op_bne:
			begin
				wr = 1'b0;
				if ((ins[31:26] == op_beq) ? (a == b) : (a != b))
					next_pc = pc + 1 + imm_s; // no delay slot
			end
			default: wr = 1'b0;
		endcase
		if (wr && dst != '0)
		begin
			regs[dst] = res;
			exp_wr.push_back({steps, prog_tag[pc], 27'b0, dst, res});
		end
		steps++;
		if (next_pc == pc)
			break; // closing self-branch
		pc = next_pc;
	end
	return steps;
endfunction

`endif

// File: tb_mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_core
	import mips_pkg::*;
();
	localparam int prog_words = 64;
	localparam int dmem_words = 64;
	localparam int max_steps  = 1000;

	typedef struct packed {
		logic [31:0] seq; // dynamic instruction number
		logic [31:0] tag; // test that owns the event
		word_t       addr; // register number or data word index
		word_t       data;
	} event_t;

	logic      clk = 1'b0;
	logic      rst;
	pc_t       imem_addr;
	word_t     imem_data;
	logic      dmem_we;
	word_t     dmem_addr;
	word_t     dmem_wdata;
	word_t     dmem_rdata;
	logic      wb_valid;
	reg_addr_t wb_reg;
	word_t     wb_data;

	word_t  prog [0:prog_words-1];
	int     prog_tag [0:prog_words-1];
	int     prog_len;
	word_t  dmem [0:dmem_words-1];
	event_t exp_wr [$];
	event_t exp_st [$];
	int     test_err [1:6];
	int     remaining [1:6];
	string  test_name [1:6];
	int     checks;
	int     errors;
	int     passed;
	int     failed;
	int     cycles;
	int     cycle_limit;

	mips_core mips_core_inst (
		.clk        (clk),
		.rst        (rst),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_we    (dmem_we),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.wb_valid   (wb_valid),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data)
	);

	always #20 clk = ~clk;

	// both memories answer in the same cycle
	assign imem_data  = (imem_addr < prog_words) ? prog[imem_addr] : '0;
	assign dmem_rdata = dmem[dmem_addr % dmem_words];

	always @(posedge clk)
	begin
		if (dmem_we)
			dmem[dmem_addr % dmem_words] <= dmem_wdata;
	end

	function automatic word_t r_instr(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		shamt_t sh);
		return {op_rtype, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t i_instr(opcode_t op, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic put_instr(word_t w, int tag);
		prog[prog_len]     = w;
		prog_tag[prog_len] = tag;
		prog_len++;
	endtask

	task automatic build_program();
		logic [15:0] imm_a;
		logic [15:0] imm_b;
		logic [15:0] imm_n;
		logic [15:0] imm_m;
		logic [15:0] off;
		shamt_t      sh_a;
		shamt_t      sh_b;
		shamt_t      sh_c;
		int          loop_at;
		int          i;

		for (i = 0; i < prog_words; i++)
		begin
			prog[i]     = '0;
			prog_tag[i] = 0;
		end
		prog_len = 0;
		imm_a = $urandom;
		imm_b = $urandom;
		imm_n = $urandom | 32'h8000; // negative once sign-extended
		imm_m = $urandom | 32'h8000;
		sh_a  = $urandom;
		sh_b  = $urandom;
		sh_c  = $urandom;
		put_instr(i_instr(op_addi, 0, 1, imm_a), 2);
		put_instr(i_instr(op_addi, 1, 2, imm_b), 2);
		put_instr(i_instr(op_ori, 0, 3, imm_n), 2); // upper half stays zero
		put_instr(r_instr(fn_add, 1, 2, 4, 0), 2);
		put_instr(r_instr(fn_sub, 4, 3, 5, 0), 2);
		put_instr(i_instr(op_addi, 0, 6, imm_n), 2);
		put_instr(i_instr(op_slti, 6, 7, imm_m), 2); // both operands negative
		put_instr(r_instr(fn_slt, 6, 1, 8, 0), 2);
		put_instr(r_instr(fn_and, 4, 5, 9, 0), 2);
		put_instr(r_instr(fn_or, 9, 3, 10, 0), 2);
		put_instr(r_instr(fn_xor, 10, 5, 11, 0), 2);
		put_instr(r_instr(fn_nor, 11, 6, 12, 0), 2);
		put_instr(r_instr(fn_sll, 0, 12, 13, sh_a), 2);
		put_instr(r_instr(fn_srl, 0, 13, 14, sh_b), 2);
		put_instr(r_instr(fn_sra, 0, 6, 15, sh_c), 2);
		put_instr(i_instr(op_xori, 15, 16, imm_b), 2);
		put_instr(i_instr(op_andi, 16, 17, imm_a), 2);
		put_instr(i_instr(op_addi, 0, 20, 16'd8), 3); // data base
		put_instr(i_instr(op_sw, 20, 4, 16'd0), 3);
		put_instr(i_instr(op_sw, 20, 5, 16'd1), 3);
		put_instr(i_instr(op_lw, 20, 21, 16'd0), 3);
		put_instr(r_instr(fn_add, 21, 3, 22, 0), 3); // load-use
		put_instr(i_instr(op_lw, 20, 23, 16'd1), 3);
		put_instr(i_instr(op_sw, 20, 23, 16'd2), 3); // loaded value stored next
		put_instr(i_instr(op_lw, 20, 24, 16'd2), 3);
		put_instr(i_instr(op_addi, 0, 25, 16'd3), 4); // loop count
		put_instr(i_instr(op_addi, 0, 26, 16'd0), 4);
		loop_at = prog_len;
		put_instr(i_instr(op_addi, 26, 26, 16'd5), 4);
		put_instr(i_instr(op_addi, 25, 25, 16'hffff), 4);
		off = loop_at - (prog_len + 1);
		put_instr(i_instr(op_bne, 25, 0, off), 4);
		put_instr(i_instr(op_addi, 0, 27, 16'd1), 4); // wrong path while looping
		put_instr(i_instr(op_beq, 0, 0, 16'd1), 4);
		put_instr(i_instr(op_addi, 0, 28, 16'h7f), 4); // never executes
		put_instr(i_instr(op_addi, 0, 29, 16'd2), 4);
		put_instr(i_instr(op_addi, 0, 18, imm_b), 5); // stale r18 and r19 are both zero
		put_instr(i_instr(op_addi, 18, 19, 16'd1), 5);
		put_instr(i_instr(op_beq, 18, 19, 16'd1), 5); // not taken
		put_instr(i_instr(op_addi, 19, 3, 16'd0), 5);
		put_instr(i_instr(op_xori, 3, 4, 16'd0), 5);
		put_instr(i_instr(op_bne, 3, 4, 16'd1), 5); // not taken
		put_instr(i_instr(op_sw, 20, 4, 16'd3), 5);
		put_instr(i_instr(op_beq, 0, 0, 16'hffff), 5); // park here
	endtask

	task automatic count_error(int tag);
		test_err[tag]++;
		errors++;
	endtask

	task automatic check_value(string name, word_t got, word_t want, int tag);
		checks++;
		if (got !== want)
		begin
			$display("ERROR: %s is 0x%h, expected 0x%h", name, got, want);
			count_error(tag);
		end
	endtask

	task automatic report_test(int t);
		if (test_err[t] == 0)
		begin
			passed++;
			$display("test %0d %s: passed", t, test_name[t]);
		end
		else
		begin
			failed++;
			$display("test %0d %s: failed with %0d errors", t, test_name[t], test_err[t]);
		end
	endtask

	task automatic retire(int tag);
		remaining[tag]--;
		if (remaining[tag] == 0)
			report_test(tag); // last event of this test
	endtask

	task automatic take_write();
		event_t e;

		if (exp_wr.size() == 0)
		begin
			$display("unexpected register write to r%0d with 0x%h", wb_reg, wb_data);
			count_error(6);
			return;
		end
		e = exp_wr.pop_front();
		if (exp_st.size() > 0 && exp_st[0].seq < e.seq)
		begin
			$display("register write of instruction %0d came before the store of instruction %0d",
				e.seq, exp_st[0].seq);
			count_error(6);
		end
		check_value("wb_reg", wb_reg, e.addr, e.tag);
		check_value("wb_data", wb_data, e.data, e.tag);
		retire(e.tag);
	endtask

	task automatic take_store();
		event_t e;

		if (exp_st.size() == 0)
		begin
			$display("unexpected store to word 0x%h with 0x%h", dmem_addr, dmem_wdata);
			count_error(6);
			return;
		end
		e = exp_st.pop_front();
		if (exp_wr.size() > 0 && exp_wr[0].seq < e.seq)
		begin
			$display("store of instruction %0d came before the register write of instruction %0d",
				e.seq, exp_wr[0].seq);
			count_error(6);
		end
		check_value("dmem_addr", dmem_addr, e.addr, e.tag);
		check_value("dmem_wdata", dmem_wdata, e.data, e.tag);
		retire(e.tag);
	endtask

	// sampled mid-cycle once outputs have settled
	always @(negedge clk)
	begin
		if (rst)
		begin
			check_value("wb_valid", wb_valid, '0, 1);
			check_value("dmem_we", dmem_we, '0, 1);
		end
		else if ($isunknown({wb_valid, dmem_we}))
		begin
			$display("wb_valid or dmem_we is unknown after reset");
			count_error(6);
		end
		else
		begin
			if (wb_valid)
				take_write(); // older instruction first
			if (dmem_we)
				take_store();
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit)
		begin
			$display("timeout after %0d cycles, %0d register writes and %0d stores never seen",
				cycles, exp_wr.size(), exp_st.size());
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial
	begin : main_flow
		int steps;
		int i;

		rst = 1'b1;
		void'($urandom(34));
		test_name[1] = "reset";
		test_name[2] = "alu and forwarding";
		test_name[3] = "loads and stores";
		test_name[4] = "taken branches";
		test_name[5] = "branch source hazards";
		test_name[6] = "ordering";
		for (i = 0; i < dmem_words; i++)
			dmem[i] = '0;
		build_program();
		steps = run_model();
		cycle_limit = 5 * steps + 100;
		foreach (exp_wr[k])
			remaining[exp_wr[k].tag]++;
		foreach (exp_st[k])
			remaining[exp_st[k].tag]++;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("imem_addr", imem_addr, '0, 1);
		report_test(1);
		while (exp_wr.size() + exp_st.size() > 0)
			@(negedge clk);
		repeat (8) @(negedge clk); // window for stray writes or stores
		@(posedge clk);
		report_test(6);
		$display("%0d tests passed, %0d failed, %0d checks, %0d errors",
			passed, failed, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

`include "mips_ref.svh"

endmodule

`default_nettype wire

// File: mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core
	import mips_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	output pc_t        imem_addr,
	input  wire word_t imem_data,
	output logic       dmem_we,
	output word_t      dmem_addr,
	output word_t      dmem_wdata,
	input  wire word_t dmem_rdata,
	output logic       wb_valid,
	output reg_addr_t  wb_reg,
	output word_t      wb_data
);
	logic  stall;
	logic  branch_taken;
	pc_t   branch_target;
	word_t id_instr;
	pc_t   id_pc_plus1;
	logic  wb_reg_write;

	id_ex_if  id_ex_bus ();
	ex_mem_if ex_mem_bus ();

	fetch_stage fetch_stage_inst (
		.clk           (clk),
		.rst           (rst),
		.stall         (stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.imem_addr     (imem_addr),
		.imem_data     (imem_data),
		.id_instr      (id_instr),
		.id_pc_plus1   (id_pc_plus1)
	);

	decode_stage decode_stage_inst (
		.clk           (clk),
		.rst           (rst),
		.id_instr      (id_instr),
		.id_pc_plus1   (id_pc_plus1),
		.stall         (stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.wb_reg_write  (wb_reg_write),
		.wb_reg        (wb_reg),
		.wb_data       (wb_data),
		.id_ex         (id_ex_bus.decode),
		.ex_mem        (ex_mem_bus.hazard)
	);

	execute_stage execute_stage_inst (
		.clk          (clk),
		.rst          (rst),
		.id_ex        (id_ex_bus.execute),
		.ex_mem       (ex_mem_bus.execute),
		.wb_reg_write (wb_reg_write),
		.wb_reg       (wb_reg),
		.wb_data      (wb_data)
	);

	mem_wb_stage mem_wb_stage_inst (
		.clk          (clk),
		.rst          (rst),
		.ex_mem       (ex_mem_bus.mem),
		.dmem_we      (dmem_we),
		.dmem_addr    (dmem_addr),
		.dmem_wdata   (dmem_wdata),
		.dmem_rdata   (dmem_rdata),
		.wb_reg_write (wb_reg_write),
		.wb_reg       (wb_reg),
		.wb_data      (wb_data)
	);

	assign wb_valid = wb_reg_write && wb_reg != '0; // writes to r0 are dropped

endmodule

`default_nettype wire

// File: mem_wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage
	import mips_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	ex_mem_if.mem      ex_mem,
	output logic       dmem_we,
	output word_t      dmem_addr,
	output word_t      dmem_wdata,
	input  wire word_t dmem_rdata,
	output logic       wb_reg_write,
	output reg_addr_t  wb_reg,
	output word_t      wb_data
);
	logic  mem_to_reg_q;
	word_t load_q;
	word_t alu_q;

	assign dmem_we    = ex_mem.mem_write;
	assign dmem_addr  = ex_mem.alu_result; // word index
	assign dmem_wdata = ex_mem.store_data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_reg_write <= 1'b0;
			mem_to_reg_q <= 1'b0;
		end
		else
		begin
			wb_reg_write <= ex_mem.reg_write;
			mem_to_reg_q <= ex_mem.mem_to_reg;
		end
	end

	always_ff @(posedge clk)
	begin
		load_q <= dmem_rdata;
		alu_q  <= ex_mem.alu_result;
		wb_reg <= ex_mem.dest;
	end

	assign wb_data = mem_to_reg_q ? load_q : alu_q;

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage
	import mips_pkg::*;
(
	input  wire            clk,
	input  wire            rst,
	id_ex_if.execute       id_ex,
	ex_mem_if.execute      ex_mem,
	input  wire            wb_reg_write,
	input  wire reg_addr_t wb_reg,
	input  wire word_t     wb_data
);
	word_t     fwd_a;
	word_t     fwd_b;
	word_t     alu_b;
	word_t     alu_result;
	reg_addr_t dest;

	// newest producer wins
	function automatic word_t forward(reg_addr_t src, word_t reg_val);
		if (src == '0)
			return reg_val;
		else if (ex_mem.reg_write && ex_mem.dest == src)
			return ex_mem.alu_result;
		else if (wb_reg_write && wb_reg == src)
			return wb_data;
		else
			return reg_val;
	endfunction

	always_comb
	begin
		fwd_a = forward(id_ex.rs, id_ex.rs_data);
		fwd_b = forward(id_ex.rt, id_ex.rt_data);
	end

	assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;
	assign dest  = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

	alu alu_inst (
		.op     (id_ex.ctrl.alu_op),
		.a      (fwd_a),
		.b      (alu_b),
		.shamt  (id_ex.shamt),
		.result (alu_result)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_mem.reg_write  <= 1'b0;
			ex_mem.mem_to_reg <= 1'b0;
			ex_mem.mem_read   <= 1'b0;
			ex_mem.mem_write  <= 1'b0;
		end
		else
		begin
			ex_mem.reg_write  <= id_ex.ctrl.reg_write;
			ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
			ex_mem.mem_read   <= id_ex.ctrl.mem_read;
			ex_mem.mem_write  <= id_ex.ctrl.mem_write;
		end
	end

	always_ff @(posedge clk)
	begin
		ex_mem.alu_result <= alu_result;
		ex_mem.store_data <= fwd_b; // sw data after forwarding
		ex_mem.dest       <= dest;
	end

	// decode never issues a load that also stores
	assert property (@(posedge clk) disable iff (rst) !(ex_mem.mem_read && ex_mem.mem_write));

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage
	import mips_pkg::*;
(
	input  wire            clk,
	input  wire            rst,
	input  wire word_t     id_instr,
	input  wire pc_t       id_pc_plus1,
	output logic           stall,
	output logic           branch_taken,
	output pc_t            branch_target,
	input  wire            wb_reg_write,
	input  wire reg_addr_t wb_reg,
	input  wire word_t     wb_data,
	id_ex_if.decode        id_ex,
	ex_mem_if.hazard       ex_mem
);
	opcode_t   opcode;
	funct_t    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	word_t     rs_data;
	word_t     rt_data;
	word_t     imm;
	ctrl_t     ctrl;
	logic      is_beq;
	logic      is_bne;
	reg_addr_t ex_dest;
	logic      ex_hit;
	logic      mem_hit;

	assign opcode = id_instr[31:26];
	assign funct  = id_instr[5:0];
	assign rs     = id_instr[25:21];
	assign rt     = id_instr[20:16];

	reg_file reg_file_inst (
		.clk     (clk),
		.rs      (rs),
		.rt      (rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.we      (wb_reg_write),
		.wr_reg  (wb_reg),
		.wr_data (wb_data)
	);

	always_comb
	begin
		ctrl = '0;
		case (opcode)
			op_rtype:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst   = 1'b1;
				case (funct)
					fn_add: ctrl.alu_op = alu_add;
					fn_sub: ctrl.alu_op = alu_sub;
					fn_and: ctrl.alu_op = alu_and;
					fn_or:  ctrl.alu_op = alu_or;
					fn_xor: ctrl.alu_op = alu_xor;
					fn_nor: ctrl.alu_op = alu_nor;
					fn_slt: ctrl.alu_op = alu_slt;
					fn_sll: ctrl.alu_op = alu_sll;
					fn_srl: ctrl.alu_op = alu_srl;
					fn_sra: ctrl.alu_op = alu_sra;
					default: ctrl = '0; // unsupported funct
				endcase
			end
			op_addi, op_slti, op_andi, op_ori, op_xori:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.zero_ext  = (opcode == op_ori);
				case (opcode)
					op_slti: ctrl.alu_op = alu_slt;
					op_andi: ctrl.alu_op = alu_and;
					op_ori:  ctrl.alu_op = alu_or;
					op_xori: ctrl.alu_op = alu_xor;
					default: ctrl.alu_op = alu_add;
				endcase
			end
			op_lw:
			begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.alu_src    = 1'b1;
			end
			op_sw:
			begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
			end
			default: ctrl = '0; // branches and unknown opcodes
		endcase
		if (id_instr == '0)
			ctrl = '0; // flushed slot
	end

	assign imm = ctrl.zero_ext ? {16'b0, id_instr[15:0]} : {{16{id_instr[15]}}, id_instr[15:0]};

	assign is_beq        = (opcode == op_beq);
	assign is_bne        = (opcode == op_bne);
	assign branch_target = id_pc_plus1 + imm;

	// older writers still in flight
	assign ex_dest = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
	assign ex_hit  = id_ex.ctrl.reg_write && ex_dest != '0 && (ex_dest == rs || ex_dest == rt);
	assign mem_hit = ex_mem.reg_write && ex_mem.dest != '0
		&& (ex_mem.dest == rs || ex_mem.dest == rt);

	assign stall = (id_ex.ctrl.mem_read && ex_hit) || ((is_beq || is_bne) && (ex_hit || mem_hit));

	assign branch_taken = !stall
		&& ((is_beq && rs_data == rt_data) || (is_bne && rs_data != rt_data));

	always_ff @(posedge clk)
	begin
		if (rst || stall)
			id_ex.ctrl <= '0; // bubble
		else
			id_ex.ctrl <= ctrl;
	end

	always_ff @(posedge clk)
	begin
		id_ex.rs_data <= rs_data;
		id_ex.rt_data <= rt_data;
		id_ex.imm     <= imm;
		id_ex.rs      <= rs;
		id_ex.rt      <= rt;
		id_ex.rd      <= id_instr[15:11];
		id_ex.shamt   <= id_instr[10:6];
	end

endmodule

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
	import mips_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	input  wire        stall,
	input  wire        branch_taken,
	input  wire pc_t   branch_target,
	output pc_t        imem_addr,
	input  wire word_t imem_data,
	output word_t      id_instr,
	output pc_t        id_pc_plus1
);
	pc_t pc;
	pc_t pc_plus1;

	assign pc_plus1  = pc + 1;
	assign imem_addr = pc; // memory answers in the same cycle

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc       <= '0;
			id_instr <= '0;
		end
		else if (!stall)
		begin
			pc       <= branch_taken ? branch_target : pc_plus1;
			id_instr <= branch_taken ? '0 : imem_data; // squash wrong-path fetch
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
			id_pc_plus1 <= pc_plus1;
	end

	// decode never redirects while it holds the front end
	assert property (@(posedge clk) disable iff (rst) !(stall && branch_taken));

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file
	import mips_pkg::*;
(
	input  wire            clk,
	input  wire reg_addr_t rs,
	input  wire reg_addr_t rt,
	output word_t          rs_data,
	output word_t          rt_data,
	input  wire            we,
	input  wire reg_addr_t wr_reg,
	input  wire word_t     wr_data
);
	word_t regs [0:31];

	function automatic word_t read_port(reg_addr_t addr);
		if (addr == '0)
			return '0;
		else if (we && wr_reg == addr)
			return wr_data; // value being written this cycle
		else
			return regs[addr];
	endfunction

	always_comb
	begin
		rs_data = read_port(rs);
		rt_data = read_port(rt);
	end

	always_ff @(posedge clk)
	begin
		if (we && wr_reg != '0)
			regs[wr_reg] <= wr_data;
	end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
	import mips_pkg::*;
(
	input  wire alu_op_e op,
	input  wire word_t   a,
	input  wire word_t   b,
	input  wire shamt_t  shamt,
	output word_t        result
);
	logic less; // signed compare for slt and slti

	assign less = $signed(a) < $signed(b);

	always_comb
	begin
		case (op)
			alu_add:
				result = a + b;
			alu_sub:
				result = a - b;
			alu_and:
				result = a & b;
			alu_or:
				result = a | b;
			alu_xor:
				result = a ^ b;
			alu_nor:
				result = ~(a | b);
			alu_slt:
				result = {{(xlen-1){1'b0}}, less};
			alu_sll:
				result = b << shamt;
			alu_srl:
				result = b >> shamt;
			alu_sra:
				result = $signed(b) >>> shamt; // keeps sign bit
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: pipe_intf.sv
`timescale 1ns/1ns
`default_nettype none

interface id_ex_if
	import mips_pkg::*;
();
	ctrl_t     ctrl;
	word_t     rs_data;
	word_t     rt_data;
	word_t     imm; // already extended
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	shamt_t    shamt;

	modport decode (
		output ctrl, rs_data, rt_data, imm, rs, rt, rd, shamt
	);

	modport execute (
		input ctrl, rs_data, rt_data, imm, rs, rt, rd, shamt
	);
endinterface

interface ex_mem_if
	import mips_pkg::*;
();
	logic      reg_write;
	logic      mem_to_reg;
	logic      mem_read;
	logic      mem_write;
	word_t     alu_result; // also the data word index
	word_t     store_data;
	reg_addr_t dest;

	modport execute (
		output reg_write, mem_to_reg, mem_read, mem_write, alu_result, store_data, dest
	);

	modport mem (
		input reg_write, mem_to_reg, mem_read, mem_write, alu_result, store_data, dest
	);

	// branch source check in decode
	modport hazard (
		input reg_write, dest
	);
endinterface

`default_nettype wire

// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [31:0]     pc_t; // instruction index, not byte address
	typedef logic [4:0]      reg_addr_t;
	typedef logic [4:0]      shamt_t;
	typedef logic [5:0]      opcode_t;
	typedef logic [5:0]      funct_t;

	localparam opcode_t op_rtype = 6'd0;
	localparam opcode_t op_beq   = 6'd4;
	localparam opcode_t op_bne   = 6'd5;
	localparam opcode_t op_addi  = 6'd8;
	localparam opcode_t op_slti  = 6'd10;
	localparam opcode_t op_andi  = 6'd12;
	localparam opcode_t op_ori   = 6'd13;
	localparam opcode_t op_xori  = 6'd14;
	localparam opcode_t op_lw    = 6'd35;
	localparam opcode_t op_sw    = 6'd43;

	localparam funct_t fn_sll = 6'h00;
	localparam funct_t fn_srl = 6'h02;
	localparam funct_t fn_sra = 6'h03;
	localparam funct_t fn_add = 6'h20;
	localparam funct_t fn_sub = 6'h22;
	localparam funct_t fn_and = 6'h24;
	localparam funct_t fn_or  = 6'h25;
	localparam funct_t fn_xor = 6'h26;
	localparam funct_t fn_nor = 6'h27;
	localparam funct_t fn_slt = 6'h2a;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_nor, alu_slt, alu_sll, alu_srl, alu_sra
	} alu_op_e;

	// all-zero value is a bubble
	typedef struct packed {
		logic    reg_write;
		logic    mem_to_reg;
		logic    mem_read;
		logic    mem_write;
		logic    alu_src; // immediate as second operand
		logic    reg_dst; // rd instead of rt
		logic    zero_ext;
		alu_op_e alu_op;
	} ctrl_t;

endpackage

`default_nettype wire
